// File: bus_integrity_monitor.f
design/bus_integrity_pkg.sv
design/achk_gen.sv
design/req_integrity_checker.sv
design/integrity_apb_regs.sv
design/bus_integrity_monitor.sv
tb/tb_clk_gen.sv
tb/bus_integrity_monitor_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the bus integrity monitor testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --timescale 1ns/100ps \
  --top-module bus_integrity_monitor_tb -f bus_integrity_monitor.f \
  --Mdir build/obj_dir -o sim_tb > build/build.log 2>&1 \
  || { cat build/build.log; echo "Verilator build failed"; exit 1; }

./build/obj_dir/sim_tb > build/sim.log 2>&1 || true
cat build/sim.log

grep -q "Simulation finished: FAIL" build/sim.log && { echo "Test failed"; exit 1; }
echo "Test passed" && exit 0

// File: tb/bus_integrity_monitor_tb.sv
// Testbench for the bus integrity monitor with LFSR traffic, a reference
// model of the per-port error state, APB tasks and directed checks

`timescale 1ns/100ps

module bus_integrity_monitor_tb;

  typedef bus_integrity_pkg::data_t     data_t;
  typedef bus_integrity_pkg::addr_t     addr_t;
  typedef bus_integrity_pkg::achk_t     achk_t;
  typedef bus_integrity_pkg::apb_addr_t apb_addr_t;
  typedef bus_integrity_pkg::bus_req_t  bus_req_t;
  typedef bus_integrity_pkg::bus_intg_t bus_intg_t;

  // Narrow counters so that saturation is reached quickly
  localparam int CNT_W      = 4;
  localparam int WAIT_LIMIT = 16;
  localparam int MAX_CYCLES = 20000;

  // Mirrored error state of one port
  typedef struct packed {
    logic             err;
    logic [CNT_W-1:0] cnt;
    addr_t            addr;
  } port_state_t;

  logic                        clk;
  logic                        rst_n;
  bus_req_t                    instr_req;
  bus_intg_t                   instr_intg;
  bus_req_t                    data_req;
  bus_intg_t                   data_intg;
  bus_integrity_pkg::apb_req_t apb_req;
  bus_integrity_pkg::apb_rsp_t apb_rsp;
  // Index 0 is the instruction port, index 1 the data port
  port_state_t                 m_st [2];
  logic [1:0]                  m_clr;
  logic [31:0]                 lfsr_q;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  bus_integrity_monitor #(
    .ERR_CNT_W (CNT_W)
  ) u_bus_integrity_monitor (
    .clk          (clk),
    .rst_ni       (rst_n),
    .instr_req_i  (instr_req),
    .instr_intg_i (instr_intg),
    .data_req_i   (data_req),
    .data_intg_i  (data_intg),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////

  // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic even_ones(input data_t v);
    return ($countones(v) % 2) == 0;
  endfunction

  function automatic achk_t ref_achk(input bus_req_t r, input bit instr);
    achk_t c;
    data_t side;
    data_t wd;
    // A fetch counts as a full-word read without write data
    side = instr ? data_t'(5'b11110) : data_t'({r.be, r.we});
    wd   = instr ? '0 : r.wdata;
    for (int i = 0; i < 4; i++) begin
      c[i]   = even_ones((r.addr >> (8 * i)) & 32'hFF);
      c[8+i] = even_ones((wd >> (8 * i)) & 32'hFF);
    end
    c[4] = even_ones(data_t'({r.prot, r.memtype}));
    c[5] = even_ones(side);
    c[6] = ~r.dbg;
    c[7] = 1'b1;
    return c;
  endfunction

  function automatic logic expect_err(input bus_req_t r, input bus_intg_t g, input bit instr);
    return (g.reqpar == r.req) || (r.req && (g.achk != ref_achk(r, instr)));
  endfunction

  function automatic port_state_t next_state(input port_state_t s, input logic err,
                                             input logic clr, input addr_t a);
    port_state_t n;
    n = s;
    if (clr) begin
      n = '0;
    end else if (err) begin
      n.err  = 1'b1;
      n.cnt  = (s.cnt == {CNT_W{1'b1}}) ? s.cnt : s.cnt + CNT_W'(1);
      n.addr = s.err ? s.addr : a;
    end
    return n;
  endfunction

  // STATUS write in its access phase clears the selected ports
  assign m_clr = (apb_req.psel && apb_req.penable && apb_req.pwrite &&
                  apb_req.paddr == bus_integrity_pkg::REG_STATUS) ?
                 apb_req.pwdata[1:0] : 2'b00;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_st[0] <= '0;
      m_st[1] <= '0;
    end else begin
      m_st[0] <= next_state(m_st[0], expect_err(instr_req, instr_intg, 1'b1),
                            m_clr[0], instr_req.addr);
      m_st[1] <= next_state(m_st[1], expect_err(data_req, data_intg, 1'b0),
                            m_clr[1], data_req.addr);
    end
  end

  // Register view of the model
  function automatic data_t model_reg(input apb_addr_t a);
    case (a)
      bus_integrity_pkg::REG_STATUS:     return data_t'({m_st[1].err, m_st[0].err});
      bus_integrity_pkg::REG_INSTR_CNT:  return data_t'(m_st[0].cnt);
      bus_integrity_pkg::REG_DATA_CNT:   return data_t'(m_st[1].cnt);
      bus_integrity_pkg::REG_INSTR_ADDR: return m_st[0].addr;
      bus_integrity_pkg::REG_DATA_ADDR:  return m_st[1].addr;
      default:                           return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic report_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      report_failure();
    end
  endtask

  // Hard limit on the whole run
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    report_failure();
  end

  ////////////////////////////////////////////////////////////
  // Bus stimulus
  ////////////////////////////////////////////////////////////

  // Idle on both ports with the parity bit correct
  task automatic drive_idle();
    instr_req         = '0;
    instr_intg        = '0;
    instr_intg.reqpar = 1'b1;
    data_req          = '0;
    data_intg         = '0;
    data_intg.reqpar  = 1'b1;
  endtask

  function automatic bus_req_t rand_req();
    bus_req_t r;
    r.req     = (rand_bits(2) != 0);
    r.we      = 1'(rand_bits(1));
    r.be      = 4'(rand_bits(4));
    r.addr    = rand_bits(32);
    r.wdata   = rand_bits(32);
    r.prot    = 3'(rand_bits(3));
    r.memtype = 2'(rand_bits(2));
    r.dbg     = 1'(rand_bits(1));
    return r;
  endfunction

  // Correct integrity bits or ones with a single checksum or parity bit flipped
  function automatic bus_intg_t make_intg(input bus_req_t r, input bit instr, input bit inject);
    bus_intg_t  g;
    logic [1:0] pick;
    int         pos;
    g.reqpar = ~r.req;
    g.achk   = ref_achk(r, instr);
    if (inject) begin
      pick = 2'(rand_bits(2));
      if (pick == 2'd0) begin
        pos = int'(rand_bits(4)) % 12;
        g.achk[pos] = ~g.achk[pos];
      end else if (pick == 2'd1) begin
        g.reqpar = ~g.reqpar;
      end
    end
    return g;
  endfunction

  task automatic drive_traffic(input int cycles, input bit inject);
    repeat (cycles) begin
      @(negedge clk);
      instr_req  = rand_req();
      instr_intg = make_intg(instr_req, 1'b1, inject);
      data_req   = rand_req();
      data_intg  = make_intg(data_req, 1'b0, inject);
    end
    @(negedge clk);
    drive_idle();
  endtask

  // One request on one port for a single cycle
  task automatic send_req(input bit data_port, input bus_req_t r, input bus_intg_t g);
    @(negedge clk);
    drive_idle();
    if (data_port) begin
      data_req  = r;
      data_intg = g;
    end else begin
      instr_req  = r;
      instr_intg = g;
    end
    @(negedge clk);
    drive_idle();
  endtask

  ////////////////////////////////////////////////////////////
  // APB access
  ////////////////////////////////////////////////////////////

  task automatic apb_xfer(input bit wr, input apb_addr_t a, input data_t wd,
                          output data_t rd, output logic slverr);
    int waits;
    @(negedge clk);
    apb_req        = '0;
    apb_req.psel   = 1'b1;
    apb_req.pwrite = wr;
    apb_req.paddr  = a;
    apb_req.pwdata = wd;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    waits = 0;
    while (apb_rsp.pready !== 1'b1) begin
      waits++;
      if (waits > WAIT_LIMIT) begin
        $display("timeout: APB slave never raised pready at offset %h", a);
        report_failure();
      end
      @(negedge clk);
      #1;
    end
    // The slave adds no wait states
    check_data("APB wait states", data_t'(waits), 32'h0);
    rd     = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_read(input apb_addr_t a, output data_t rd, output logic slverr);
    apb_xfer(1'b0, a, '0, rd, slverr);
  endtask

  task automatic apb_write(input apb_addr_t a, input data_t wd, output logic slverr);
    data_t unused;
    apb_xfer(1'b1, a, wd, unused, slverr);
  endtask

  task automatic check_reg(input apb_addr_t a, input string name);
    data_t rd;
    logic  slv;
    apb_read(a, rd, slv);
    check_data(name, rd, model_reg(a));
    check_flag({name, " pslverr"}, slv, 1'b0);
  endtask

  task automatic check_regs();
    check_reg(bus_integrity_pkg::REG_STATUS, "STATUS");
    check_reg(bus_integrity_pkg::REG_INSTR_CNT, "INSTR_CNT");
    check_reg(bus_integrity_pkg::REG_DATA_CNT, "DATA_CNT");
    check_reg(bus_integrity_pkg::REG_INSTR_ADDR, "INSTR_ADDR");
    check_reg(bus_integrity_pkg::REG_DATA_ADDR, "DATA_ADDR");
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_seq
    data_t     rd;
    logic      slv;
    int        waits;
    bus_req_t  r;
    bus_intg_t g;

    lfsr_q  = 32'd392;
    apb_req = '0;
    drive_idle();

    waits = 0;
    while (rst_n !== 1'b1) begin
      if (waits > WAIT_LIMIT) begin
        $display("timeout: reset was never released");
        report_failure();
      end
      waits++;
      @(negedge clk);
    end

    // Out of reset every register is zero
    check_regs();
    apb_read(bus_integrity_pkg::REG_STATUS, rd, slv);
    check_data("STATUS after reset", rd, 32'h0);

    // Clean traffic with idle cycles included
    drive_traffic(200, 1'b0);
    check_regs();
    apb_read(bus_integrity_pkg::REG_STATUS, rd, slv);
    check_data("STATUS after clean traffic", rd, 32'h0);

    // A short burst keeps the counters below saturation
    drive_traffic(6, 1'b1);
    check_regs();
    drive_traffic(150, 1'b1);
    check_regs();
    apb_read(bus_integrity_pkg::REG_STATUS, rd, slv);
    check_data("STATUS after injected errors", rd, 32'h3);

    apb_write(bus_integrity_pkg::REG_STATUS, 32'h3, slv);
    check_flag("STATUS write pslverr", slv, 1'b0);
    check_regs();

    // Checksum built with the fetch forcing while be and we differ from it
    r        = rand_req();
    r.req    = 1'b1;
    r.we     = 1'b1;
    r.be     = 4'b0101;
    g.reqpar = 1'b0;
    g.achk   = ref_achk(r, 1'b1);
    send_req(1'b0, r, g);
    send_req(1'b1, r, g);
    check_regs();
    apb_read(bus_integrity_pkg::REG_STATUS, rd, slv);
    check_data("STATUS after be, we and wdata test", rd, 32'h2);

    // Clearing the instruction port leaves the data port alone
    g.reqpar = 1'b1;
    send_req(1'b0, r, g);
    apb_write(bus_integrity_pkg::REG_STATUS, 32'h1, slv);
    check_regs();
    apb_read(bus_integrity_pkg::REG_STATUS, rd, slv);
    check_data("STATUS after instruction clear", rd, 32'h2);

    // Parity error held long enough to pass the counter maximum
    @(negedge clk);
    data_req  = '0;
    data_intg = '0;
    repeat (20) @(negedge clk);
    drive_idle();
    apb_read(bus_integrity_pkg::REG_DATA_CNT, rd, slv);
    check_data("saturated DATA_CNT", rd, 32'hF);
    check_regs();

    // An error in the clear access cycle loses to the clear, and the
    // instruction port keeps the errors it picks up meanwhile
    @(negedge clk);
    instr_req  = '0;
    instr_intg = '0;
    data_req   = '0;
    data_intg  = '0;
    apb_write(bus_integrity_pkg::REG_STATUS, 32'h2, slv);
    drive_idle();
    apb_read(bus_integrity_pkg::REG_DATA_CNT, rd, slv);
    check_data("DATA_CNT after clear with error", rd, 32'h0);
    apb_read(bus_integrity_pkg::REG_STATUS, rd, slv);
    check_data("STATUS after data clear", rd, 32'h1);
    check_regs();

    // Unmapped offsets answer with pslverr and change nothing
    drive_traffic(20, 1'b1);
    check_regs();
    apb_read(8'h14, rd, slv);
    check_flag("pslverr on read of 0x14", slv, 1'b1);
    apb_write(8'h14, 32'hFFFF_FFFF, slv);
    check_flag("pslverr on write of 0x14", slv, 1'b1);
    apb_write(8'h02, 32'h3, slv);
    check_flag("pslverr on write of 0x02", slv, 1'b1);
    apb_write(bus_integrity_pkg::REG_INSTR_CNT, 32'hFFFF_FFFF, slv);
    check_flag("pslverr on counter write", slv, 1'b0);
    check_regs();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
// Testbench clock and reset source, 4 ns period and a 3-cycle reset

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int HALF_NS    = 2,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_NS) clk_o = ~clk_o;
    end
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: design/bus_integrity_monitor.sv
// Bus integrity monitor top level with the instruction and data
// checkers and the APB register block

`timescale 1ns/100ps

module bus_integrity_monitor #(
  parameter int ERR_CNT_W = 16
) (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  bus_integrity_pkg::bus_req_t  instr_req_i,
  input  bus_integrity_pkg::bus_intg_t instr_intg_i,
  input  bus_integrity_pkg::bus_req_t  data_req_i,
  input  bus_integrity_pkg::bus_intg_t data_intg_i,
  input  bus_integrity_pkg::apb_req_t  apb_req_i,
  output bus_integrity_pkg::apb_rsp_t  apb_rsp_o
);

  logic                     instr_err;
  logic                     data_err;
  logic [ERR_CNT_W-1:0]     instr_cnt;
  logic [ERR_CNT_W-1:0]     data_cnt;
  bus_integrity_pkg::addr_t instr_addr;
  bus_integrity_pkg::addr_t data_addr;
  logic                     instr_clear;
  logic                     data_clear;

  // Instruction port, be, we and wdata are ignored by the checksum
  req_integrity_checker #(
    .INSTR_PORT (1'b1),
    .ERR_CNT_W  (ERR_CNT_W)
  ) u_instr_checker (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .req_i      (instr_req_i),
    .intg_i     (instr_intg_i),
    .clear_i    (instr_clear),
    .err_o      (instr_err),
    .err_cnt_o  (instr_cnt),
    .err_addr_o (instr_addr)
  );

  req_integrity_checker #(
    .INSTR_PORT (1'b0),
    .ERR_CNT_W  (ERR_CNT_W)
  ) u_data_checker (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .req_i      (data_req_i),
    .intg_i     (data_intg_i),
    .clear_i    (data_clear),
    .err_o      (data_err),
    .err_cnt_o  (data_cnt),
    .err_addr_o (data_addr)
  );

  integrity_apb_regs #(
    .ERR_CNT_W (ERR_CNT_W)
  ) u_apb_regs (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .apb_req_i     (apb_req_i),
    .instr_err_i   (instr_err),
    .data_err_i    (data_err),
    .instr_cnt_i   (instr_cnt),
    .data_cnt_i    (data_cnt),
    .instr_addr_i  (instr_addr),
    .data_addr_i   (data_addr),
    .apb_rsp_o     (apb_rsp_o),
    .instr_clear_o (instr_clear),
    .data_clear_o  (data_clear)
  );

endmodule

// File: design/integrity_apb_regs.sv
// APB register block with address decode, read mux,
// write-one-to-clear pulses and slave error on unmapped offsets

`timescale 1ns/100ps

module integrity_apb_regs #(
  parameter int ERR_CNT_W = 16
) (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  bus_integrity_pkg::apb_req_t apb_req_i,
  input  logic                       instr_err_i,
  input  logic                       data_err_i,
  input  logic [ERR_CNT_W-1:0]       instr_cnt_i,
  input  logic [ERR_CNT_W-1:0]       data_cnt_i,
  input  bus_integrity_pkg::addr_t    instr_addr_i,
  input  bus_integrity_pkg::addr_t    data_addr_i,
  output bus_integrity_pkg::apb_rsp_t apb_rsp_o,
  output logic                       instr_clear_o,
  output logic                       data_clear_o
);

  logic                     setup;
  logic                     access;
  logic                     hit_status;
  logic                     hit_instr_cnt;
  logic                     hit_data_cnt;
  logic                     hit_instr_addr;
  logic                     hit_data_addr;
  logic                     addr_valid;
  logic [1:0]               clear_q;
  bus_integrity_pkg::data_t rdata;

  ////////////////////////////////////////////////////////////
  // Phase and address decode
  ////////////////////////////////////////////////////////////

  assign setup  = apb_req_i.psel && !apb_req_i.penable;
  assign access = apb_req_i.psel && apb_req_i.penable;

  // paddr is held stable from setup through access
  assign hit_status     = (apb_req_i.paddr == bus_integrity_pkg::REG_STATUS);
  assign hit_instr_cnt  = (apb_req_i.paddr == bus_integrity_pkg::REG_INSTR_CNT);
  assign hit_data_cnt   = (apb_req_i.paddr == bus_integrity_pkg::REG_DATA_CNT);
  assign hit_instr_addr = (apb_req_i.paddr == bus_integrity_pkg::REG_INSTR_ADDR);
  assign hit_data_addr  = (apb_req_i.paddr == bus_integrity_pkg::REG_DATA_ADDR);

  assign addr_valid = hit_status || hit_instr_cnt || hit_data_cnt ||
                      hit_instr_addr || hit_data_addr;

  ////////////////////////////////////////////////////////////
  // Clear pulses
  ////////////////////////////////////////////////////////////

  // STATUS writes are decoded in the setup phase, so each clear line
  // is high for exactly the access cycle and the checkers act at its end
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_q <= 2'b00;
    end else if (setup && apb_req_i.pwrite && hit_status) begin
      clear_q <= apb_req_i.pwdata[1:0];
    end else begin
      clear_q <= 2'b00;
    end
  end

  assign instr_clear_o = clear_q[0];
  assign data_clear_o  = clear_q[1];

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  // Counters are zero-extended to the full data width
  always_comb begin
    rdata = '0;
    if (access && !apb_req_i.pwrite) begin
      if (hit_status) begin
        rdata[1:0] = {data_err_i, instr_err_i};
      end else if (hit_instr_cnt) begin
        rdata[ERR_CNT_W-1:0] = instr_cnt_i;
      end else if (hit_data_cnt) begin
        rdata[ERR_CNT_W-1:0] = data_cnt_i;
      end else if (hit_instr_addr) begin
        rdata = instr_addr_i;
      end else if (hit_data_addr) begin
        rdata = data_addr_i;
      end
    end
  end

  // No wait states, every transfer completes in its access phase
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access && !addr_valid;

endmodule

// File: design/req_integrity_checker.sv
// Per-port integrity checker with sticky flag, saturating error
// counter and capture of the first failing address

`timescale 1ns/100ps

module req_integrity_checker #(
  parameter bit INSTR_PORT = 1'b0,
  parameter int ERR_CNT_W  = 16
) (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  bus_integrity_pkg::bus_req_t  req_i,
  input  bus_integrity_pkg::bus_intg_t intg_i,
  input  logic                        clear_i,
  output logic                        err_o,
  output logic [ERR_CNT_W-1:0]        err_cnt_o,
  output bus_integrity_pkg::addr_t     err_addr_o
);

  bus_integrity_pkg::achk_t achk_exp;
  logic                     par_err;
  logic                     chk_err;
  logic                     err_now;
  logic                     err_q;
  logic [ERR_CNT_W-1:0]     cnt_q;
  bus_integrity_pkg::addr_t addr_q;

  // Expected checksum for the request seen this cycle
  achk_gen #(
    .INSTR_PORT (INSTR_PORT)
  ) u_achk_gen (
    .req_i  (req_i),
    .achk_o (achk_exp)
  );

  ////////////////////////////////////////////////////////////
  // Error detection
  ////////////////////////////////////////////////////////////

  // The parity bit must always be the inverse of req, also when idle
  assign par_err = (intg_i.reqpar == req_i.req);
  // The checksum is only meaningful while a request is active
  assign chk_err = req_i.req && (intg_i.achk != achk_exp);
  assign err_now = par_err || chk_err;

  ////////////////////////////////////////////////////////////
  // Error state
  ////////////////////////////////////////////////////////////

  // A clear from software has priority over an error in the same cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q  <= 1'b0;
      cnt_q  <= '0;
      addr_q <= '0;
    end else if (clear_i) begin
      err_q  <= 1'b0;
      cnt_q  <= '0;
      addr_q <= '0;
    end else if (err_now) begin
      err_q <= 1'b1;
      // Counter sticks at all ones once it is full
      if (cnt_q != {ERR_CNT_W{1'b1}}) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Only the first failing request after a clear is kept
      if (!err_q) begin
        addr_q <= req_i.addr;
      end
    end
  end

  assign err_o      = err_q;
  assign err_cnt_o  = cnt_q;
  assign err_addr_o = addr_q;

endmodule

// File: design/achk_gen.sv
// Address-phase checksum generator for one request port

`timescale 1ns/100ps

module achk_gen #(
  // Set for the instruction port, where be, we and wdata carry no meaning
  parameter bit INSTR_PORT = 1'b0
) (
  input  bus_integrity_pkg::bus_req_t req_i,
  output bus_integrity_pkg::achk_t    achk_o
);

  // Effective fields after the instruction-port forcing
  bus_integrity_pkg::be_t   be_eff;
  logic                     we_eff;
  bus_integrity_pkg::data_t wdata_eff;

  // A fetch is always a full-word read, whatever the struct carries
  assign be_eff    = INSTR_PORT ? 4'b1111 : req_i.be;
  assign we_eff    = INSTR_PORT ? 1'b0 : req_i.we;
  assign wdata_eff = INSTR_PORT ? '0 : req_i.wdata;

  ////////////////////////////////////////////////////////////
  // Group parities
  ////////////////////////////////////////////////////////////

  // Each checksum bit is the inverted XOR of its group,
  // so an all-zero group yields a one
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      // Bits 0 to 3 cover the address bytes
      achk_o[i] = ~^req_i.addr[8*i +: 8];
      // Bits 8 to 11 cover the write data bytes
      achk_o[8+i] = ~^wdata_eff[8*i +: 8];
    end

    // Attribute groups
    achk_o[4] = ~^{req_i.prot, req_i.memtype};
    achk_o[5] = ~^{be_eff, we_eff};
    achk_o[6] = ~^req_i.dbg;

    // Reserved group of six zero bits
    achk_o[7] = ~^6'b000000;
  end

endmodule

// File: design/bus_integrity_pkg.sv
// Shared widths, request and integrity structs, APB structs and
// register offsets for the bus integrity monitor

package bus_integrity_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Bus address as issued by the core
  typedef logic [31:0] addr_t;
  // Bus write data, also used for APB read and write data
  typedef logic [31:0] data_t;
  // One enable bit per byte lane
  typedef logic [3:0]  be_t;
  // Protection attributes of a request
  typedef logic [2:0]  prot_t;
  // Memory type (bufferable, cacheable)
  typedef logic [1:0]  memtype_t;
  // Address-phase checksum, one inverted parity bit per group
  typedef logic [11:0] achk_t;
  // Byte offset into the APB register window
  typedef logic [7:0]  apb_addr_t;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // One observed request on an instruction or data port
  typedef struct packed {
    logic     req;
    logic     we;
    be_t      be;
    addr_t    addr;
    data_t    wdata;
    prot_t    prot;
    memtype_t memtype;
    logic     dbg;
  } bus_req_t;

  // Integrity signals the core drives next to each request
  typedef struct packed {
    logic  reqpar;
    achk_t achk;
  } bus_intg_t;

  // APB request from the bus master
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    data_t     pwdata;
  } apb_req_t;

  // APB response back to the master
  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // Register map, byte offsets
  localparam apb_addr_t REG_STATUS     = 8'h00;
  localparam apb_addr_t REG_INSTR_CNT  = 8'h04;
  localparam apb_addr_t REG_DATA_CNT   = 8'h08;
  localparam apb_addr_t REG_INSTR_ADDR = 8'h0C;
  localparam apb_addr_t REG_DATA_ADDR  = 8'h10;

endpackage
